// ==== logic/ctrl_regs.sv ====
// Control register bank
`timescale 1ns/100ps
module ctrl_regs
  #(parameter int N_CTRL = 8)   // Register count
   (input logic        clk,
    input logic        nreset,
    reg_access_if.ctrl acc);

   import umi_reg_pkg::*;

   localparam int IW = AW - REG_IDX_LSB;                    // Word index width
   localparam int SW = (N_CTRL > 1) ? $clog2(N_CTRL) : 1;   // Register select width

   logic [DW-1:0] regs [N_CTRL];
   logic [IW-1:0] word_idx;
   logic [IW-1:0] ofs;         // Index relative to bank base
   logic [SW-1:0] sel;
   logic          in_range;

   //##############################
   // Address decode
   //##############################
   assign word_idx = acc.addr[AW-1:REG_IDX_LSB];
   assign ofs      = word_idx - IW'(CTRL_BASE);   // Below base wraps to a huge offset
   assign in_range = (ofs < IW'(N_CTRL));
   assign sel      = ofs[SW-1:0];

   assign acc.ctrl_hit = in_range & (acc.read | acc.write);

   // Read data straight from the addressed register
   assign acc.ctrl_rddata = in_range ? regs[sel] : '0;

   //##############################
   // Register write
   //##############################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         for (int i = 0; i < N_CTRL; i++)
            regs[i] <= '0;
      end
      else if (acc.write && in_range)
      begin
         regs[sel] <= acc.wrdata;   // Full word only
      end
   end

endmodule

// ==== logic/event_counters.sv ====
// Event counter bank
`timescale 1ns/100ps
module event_counters
  #(parameter int N_CNT = 4)   // Counter count
   (input logic             clk,
    input logic             nreset,
    input logic [N_CNT-1:0] event_in,   // One event line per counter
    reg_access_if.cnt       acc);

   import umi_reg_pkg::*;

   localparam int IW = AW - REG_IDX_LSB;
   localparam int SW = (N_CNT > 1) ? $clog2(N_CNT) : 1;

   logic [DW-1:0] count [N_CNT];
   logic [IW-1:0] word_idx;
   logic [IW-1:0] ofs;
   logic [SW-1:0] sel;
   logic          in_range;
   logic          wr_hit;

   //##############################
   // Address decode
   //##############################
   assign word_idx = acc.addr[AW-1:REG_IDX_LSB];
   assign ofs      = word_idx - IW'(CNT_BASE);
   assign in_range = (ofs < IW'(N_CNT));
   assign sel      = ofs[SW-1:0];
   assign wr_hit   = acc.write & in_range;

   assign acc.cnt_hit = in_range & (acc.read | acc.write);

   // Value before this cycle's increment
   assign acc.cnt_rddata = in_range ? count[sel] : '0;

   //##############################
   // Counting
   //##############################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         for (int k = 0; k < N_CNT; k++)
            count[k] <= '0;
      end
      else
      begin
         for (int k = 0; k < N_CNT; k++)
         begin
            if (wr_hit && (sel == SW'(k)))
               count[k] <= acc.wrdata;        // Write wins over the event
            else if (event_in[k])
               count[k] <= count[k] + 1'b1;   // One per cycle held high
         end
      end
   end

endmodule

// ==== logic/reg_access_if.sv ====
// Register access bundle
`timescale 1ns/100ps
interface reg_access_if;

   import umi_reg_pkg::*;

   // Access issued by the front end, one per cycle
   logic          read;          // Read strobe
   logic          write;         // Write strobe, posted or not
   logic          resp_req;      // A response is owed
   logic [AW-1:0] addr;
   logic [DW-1:0] wrdata;
   umi_cmd_t      cmd;           // Request view
   logic [AW-1:0] srcaddr;       // Becomes response dstaddr

   // Bank replies
   logic          ctrl_hit;
   logic [DW-1:0] ctrl_rddata;
   logic          cnt_hit;
   logic [DW-1:0] cnt_rddata;

   logic          access_ready;  // Response queue has room

   modport master (output read, write, resp_req, addr, wrdata, cmd, srcaddr,
                   input  access_ready);
   modport ctrl   (input  read, write, addr, wrdata,
                   output ctrl_hit, ctrl_rddata);
   modport cnt    (input  read, write, addr, wrdata,
                   output cnt_hit, cnt_rddata);
   modport merge  (input  read, write, resp_req, addr, wrdata, cmd, srcaddr,
                   input  ctrl_hit, ctrl_rddata, cnt_hit, cnt_rddata,
                   output access_ready);

endinterface

// ==== logic/resp_merge.sv ====
// Response builder and credit sender
`timescale 1ns/100ps
module resp_merge
  #(parameter int RESP_DEPTH = 4)   // Response queue entries
   (input  logic                       clk,
    input  logic                       nreset,
    input  logic                       resp_credit,
    output logic                       resp_valid,
    output logic [umi_reg_pkg::CW-1:0] resp_cmd,
    output logic [umi_reg_pkg::AW-1:0] resp_dstaddr,
    output logic [umi_reg_pkg::AW-1:0] resp_srcaddr,
    output logic [umi_reg_pkg::DW-1:0] resp_data,
    reg_access_if.merge                acc);

   import umi_reg_pkg::*;

   localparam int PW   = (RESP_DEPTH > 1) ? $clog2(RESP_DEPTH) : 1;
   localparam int CNTW = $clog2(RESP_DEPTH + 1);
   localparam int CRW  = 16;   // Credit counter, host may grant ahead

   umi_cmd_t        rsp_cmd;     // Response view of the command
   logic [DW-1:0]   rsp_data;
   logic            any_hit;
   logic            req_is_read;

   umi_cmd_t        q_cmd [RESP_DEPTH];
   logic [AW-1:0]   q_dst [RESP_DEPTH];
   logic [DW-1:0]   q_data [RESP_DEPTH];
   logic [PW-1:0]   wr_ptr;
   logic [PW-1:0]   rd_ptr;
   logic [CNTW-1:0] fill;
   logic [CRW-1:0]  credits;     // Response credits held
   logic            not_empty;
   logic            send;

   //##############################
   // Response build
   //##############################
   assign any_hit     = acc.ctrl_hit | acc.cnt_hit;
   assign req_is_read = (acc.cmd.req.opcode == UMI_REQ_READ) ||
                        (acc.cmd.req.opcode == UMI_REQ_ATOMIC);   // Atomics answer as reads

   always_comb
   begin
      rsp_cmd             = '0;
      rsp_cmd.resp.opcode = req_is_read ? UMI_RESP_READ : UMI_RESP_WRITE;
      rsp_cmd.resp.size   = acc.cmd.req.size;   // Echo only
      rsp_cmd.resp.len    = acc.cmd.req.len;
      rsp_cmd.resp.err    = any_hit ? ERR_OK : ERR_DECODE;
   end

   // Read data from whichever bank hit, zero for writes and misses
   always_comb
   begin
      rsp_data = '0;
      if (acc.read && acc.ctrl_hit)
         rsp_data = acc.ctrl_rddata;
      else if (acc.read && acc.cnt_hit)
         rsp_data = acc.cnt_rddata;
   end

   //##############################
   // Response queue
   //##############################
   always_ff @(posedge clk)
   begin
      if (acc.resp_req)
      begin
         q_cmd[wr_ptr]  <= rsp_cmd;
         q_dst[wr_ptr]  <= acc.srcaddr;   // Reply to the requester
         q_data[wr_ptr] <= rsp_data;
      end
   end

   assign not_empty        = (fill != '0);
   assign send             = not_empty & (credits != '0);
   assign acc.access_ready = (fill != CNTW'(RESP_DEPTH));   // Free slot left

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         fill    <= '0;
         credits <= '0;
      end
      else
      begin
         if (acc.resp_req)
            wr_ptr <= (wr_ptr == PW'(RESP_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (send)
            rd_ptr <= (rd_ptr == PW'(RESP_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         fill    <= fill + CNTW'(acc.resp_req) - CNTW'(send);
         credits <= credits + CRW'(resp_credit) - CRW'(send);   // Grant and spend
      end
   end

   //##############################
   // Output beat
   //##############################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         resp_valid <= 1'b0;
      else
         resp_valid <= send;   // One cycle per response
   end

   always_ff @(posedge clk)
   begin
      if (send)
      begin
         resp_cmd     <= q_cmd[rd_ptr];
         resp_dstaddr <= q_dst[rd_ptr];
         resp_data    <= q_data[rd_ptr];
      end
   end

   assign resp_srcaddr = '0;   // No source address in responses

endmodule

// ==== logic/umi_reg_pkg.sv ====
// UMI register target definitions
package umi_reg_pkg;

   //##############################
   // Widths
   //##############################
   localparam int AW = 64;    // Address width
   localparam int DW = 64;    // Data and register width
   localparam int CW = 32;    // Command width

   //##############################
   // Opcodes and error codes
   //##############################
   localparam logic [4:0] UMI_REQ_READ         = 5'h01;
   localparam logic [4:0] UMI_REQ_WRITE        = 5'h03;
   localparam logic [4:0] UMI_REQ_WRITE_POSTED = 5'h05;
   localparam logic [4:0] UMI_REQ_ATOMIC       = 5'h09;   // Unsupported, decode error

   localparam logic [4:0] UMI_RESP_READ  = 5'h02;
   localparam logic [4:0] UMI_RESP_WRITE = 5'h04;

   localparam logic [1:0] ERR_OK     = 2'b00;
   localparam logic [1:0] ERR_DECODE = 2'b11;

   // Address map, in 64-bit word indexes
   localparam int REG_IDX_LSB = 3;   // Byte offset within a word below this
   localparam int CTRL_BASE   = 0;   // Control bank
   localparam int CNT_BASE    = 16;  // Counter bank

   // Command word, seen as request on the way in and as response on the way out
   typedef union packed {
      struct packed {
         logic       ex;
         logic       eom;
         logic [1:0] prot;
         logic [3:0] qos;
         logic [7:0] atype;
         logic [7:0] len;
         logic [2:0] size;
         logic [4:0] opcode;
      } req;
      struct packed {
         logic [13:0] reserved;   // Zero in responses
         logic [1:0]  err;
         logic [7:0]  len;
         logic [2:0]  size;
         logic [4:0]  opcode;
      } resp;
   } umi_cmd_t;

endpackage

// ==== logic/umi_reg_top.sv ====
// UMI register target top
`timescale 1ns/100ps
module umi_reg_top
  #(parameter int GRPOFFSET  = 24,
    parameter int GRPAW      = 4,
    parameter int GRPID      = 3,
    parameter int REQ_DEPTH  = 4,   // Host starts with this many credits
    parameter int RESP_DEPTH = 4,
    parameter int N_CTRL     = 8,
    parameter int N_CNT      = 4)
   (input  logic                       clk,
    input  logic                       nreset,
    // Request channel
    input  logic                       req_valid,
    input  logic [umi_reg_pkg::CW-1:0] req_cmd,
    input  logic [umi_reg_pkg::AW-1:0] req_dstaddr,
    input  logic [umi_reg_pkg::AW-1:0] req_srcaddr,
    input  logic [umi_reg_pkg::DW-1:0] req_data,
    output logic                       req_credit,
    // Response channel
    output logic                       resp_valid,
    output logic [umi_reg_pkg::CW-1:0] resp_cmd,
    output logic [umi_reg_pkg::AW-1:0] resp_dstaddr,
    output logic [umi_reg_pkg::AW-1:0] resp_srcaddr,
    output logic [umi_reg_pkg::DW-1:0] resp_data,
    input  logic                       resp_credit,
    // Counter events
    input  logic [N_CNT-1:0]           event_in);

   reg_access_if acc_if ();   // Shared access bus

   umi_regif #(.GRPOFFSET(GRPOFFSET), .GRPAW(GRPAW), .GRPID(GRPID), .REQ_DEPTH(REQ_DEPTH))
   regif0 (.clk         (clk),
           .nreset      (nreset),
           .req_valid   (req_valid),
           .req_cmd     (req_cmd),
           .req_dstaddr (req_dstaddr),
           .req_srcaddr (req_srcaddr),
           .req_data    (req_data),
           .req_credit  (req_credit),
           .acc         (acc_if.master));

   ctrl_regs #(.N_CTRL(N_CTRL))
   ctrl0 (.clk(clk), .nreset(nreset), .acc(acc_if.ctrl));

   event_counters #(.N_CNT(N_CNT))
   cnt0 (.clk(clk), .nreset(nreset), .event_in(event_in), .acc(acc_if.cnt));

   resp_merge #(.RESP_DEPTH(RESP_DEPTH))
   merge0 (.clk          (clk),
           .nreset       (nreset),
           .resp_credit  (resp_credit),
           .resp_valid   (resp_valid),
           .resp_cmd     (resp_cmd),
           .resp_dstaddr (resp_dstaddr),
           .resp_srcaddr (resp_srcaddr),
           .resp_data    (resp_data),
           .acc          (acc_if.merge));

endmodule

// ==== logic/umi_regif.sv ====
// UMI request front end
`timescale 1ns/100ps
module umi_regif
  #(parameter int GRPOFFSET = 24,   // Group field position in dstaddr
    parameter int GRPAW     = 4,    // Group field width
    parameter int GRPID     = 3,    // This device's group
    parameter int REQ_DEPTH = 4)    // Request buffer entries, also host credits
   (input  logic                         clk,
    input  logic                         nreset,
    input  logic                         req_valid,
    input  umi_reg_pkg::umi_cmd_t        req_cmd,
    input  logic [umi_reg_pkg::AW-1:0]   req_dstaddr,
    input  logic [umi_reg_pkg::AW-1:0]   req_srcaddr,
    input  logic [umi_reg_pkg::DW-1:0]   req_data,
    output logic                         req_credit,
    reg_access_if.master                 acc);

   import umi_reg_pkg::*;

   localparam int PW   = (REQ_DEPTH > 1) ? $clog2(REQ_DEPTH) : 1;
   localparam int CNTW = $clog2(REQ_DEPTH + 1);
   localparam logic [GRPAW-1:0] GRP_SEL  = GRPAW'(GRPID);
   localparam logic [AW-1:0]    GRP_MASK = AW'({GRPAW{1'b1}}) << GRPOFFSET;   // Group field bits

   // Request buffer storage
   umi_cmd_t        fifo_cmd [REQ_DEPTH];
   logic [AW-1:0]   fifo_dst [REQ_DEPTH];
   logic [AW-1:0]   fifo_src [REQ_DEPTH];
   logic [DW-1:0]   fifo_data [REQ_DEPTH];

   logic [PW-1:0]   wr_ptr;
   logic [PW-1:0]   rd_ptr;
   logic [CNTW-1:0] fill;         // Entries held

   umi_cmd_t        head_cmd;
   logic [AW-1:0]   head_dst;
   logic            not_empty;
   logic            issue;        // Head leaves the buffer this cycle
   logic            group_match;
   logic            head_read;
   logic            head_write;
   logic            head_posted;

   //##############################
   // Request buffer
   //##############################

   // Host never sends without a credit, so no full check
   always_ff @(posedge clk)
   begin
      if (req_valid)
      begin
         fifo_cmd[wr_ptr]  <= req_cmd;
         fifo_dst[wr_ptr]  <= req_dstaddr;
         fifo_src[wr_ptr]  <= req_srcaddr;
         fifo_data[wr_ptr] <= req_data;
      end
   end

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         fill   <= '0;
      end
      else
      begin
         if (req_valid)
            wr_ptr <= (wr_ptr == PW'(REQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (issue)
            rd_ptr <= (rd_ptr == PW'(REQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         fill <= fill + CNTW'(req_valid) - CNTW'(issue);
      end
   end

   assign not_empty = (fill != '0);
   assign issue     = not_empty & acc.access_ready;   // Wait for a queue slot
   assign head_cmd  = fifo_cmd[rd_ptr];
   assign head_dst  = fifo_dst[rd_ptr];

   //##############################
   // Decode and issue
   //##############################
   assign head_read   = (head_cmd.req.opcode == UMI_REQ_READ);
   assign head_write  = (head_cmd.req.opcode == UMI_REQ_WRITE);
   assign head_posted = (head_cmd.req.opcode == UMI_REQ_WRITE_POSTED);
   assign group_match = (head_dst[GRPOFFSET +: GRPAW] == GRP_SEL);

   // Misses and atomics get no strobe, only a response
   assign acc.read     = issue & group_match & head_read;
   assign acc.write    = issue & group_match & (head_write | head_posted);
   assign acc.resp_req = issue & ~head_posted;   // Posted writes stay silent

   assign acc.addr    = head_dst & ~GRP_MASK;   // Banks see the offset within the group
   assign acc.wrdata  = fifo_data[rd_ptr];
   assign acc.cmd     = head_cmd;
   assign acc.srcaddr = fifo_src[rd_ptr];

   assign req_credit = issue;   // Slot freed, one credit back

endmodule

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and pass only when the pass message shows up
out=""
verilator --binary --timing -f vlog.f --top-module tb_umi_reg_top -Mdir obj_dir -o tb_sim \
   && out=$(./obj_dir/tb_sim 2>&1)
echo "$out"
echo "$out" | grep -q "^No errors$" && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== verif/tb_vectors.svh ====
// Register access test table

// add_row columns: name, request opcode, dstaddr, write data,
// response expected, expected err, expected read data
task automatic load_vectors();
   logic [63:0] ctrl_val [N_CTRL];   // Last value written per control register
   logic [63:0] wrong_grp;
   logic [63:0] unmapped;
   wrong_grp = ctrl_addr(1) ^ (64'h1 << GRPOFFSET);   // Group 2, would hit ctrl1
   unmapped  = word_addr(10);                         // Gap between the banks
   // Everything zero out of reset
   for (int i = 0; i < N_CTRL; i++)
      add_row($sformatf("ctrl%0d after reset", i), UMI_REQ_READ, ctrl_addr(i), '0,
              1'b1, ERR_OK, '0);
   for (int k = 0; k < N_CNT; k++)
      add_row($sformatf("cnt%0d after reset", k), UMI_REQ_READ, cnt_addr(k), '0,
              1'b1, ERR_OK, '0);
   // Write, then read back
   for (int i = 0; i < N_CTRL; i++)
   begin
      ctrl_val[i] = {$urandom, $urandom};
      add_row($sformatf("ctrl%0d write", i), UMI_REQ_WRITE, ctrl_addr(i), ctrl_val[i],
              1'b1, ERR_OK, '0);
      add_row($sformatf("ctrl%0d read", i), UMI_REQ_READ, ctrl_addr(i), '0,
              1'b1, ERR_OK, ctrl_val[i]);
   end
   ctrl_val[5] = {$urandom, $urandom};   // Silent, seen only by the read
   add_row("ctrl5 posted write", UMI_REQ_WRITE_POSTED, ctrl_addr(5), ctrl_val[5],
           1'b0, ERR_OK, '0);
   add_row("ctrl5 posted read", UMI_REQ_READ, ctrl_addr(5), '0, 1'b1, ERR_OK, ctrl_val[5]);
   // Decode errors must leave ctrl1 alone
   add_row("wrong group write", UMI_REQ_WRITE, wrong_grp, 64'hdead_beef_0bad_f00d,
           1'b1, ERR_DECODE, '0);
   add_row("wrong group read", UMI_REQ_READ, wrong_grp, '0, 1'b1, ERR_DECODE, '0);
   add_row("unmapped write", UMI_REQ_WRITE, unmapped, 64'h5a5a_5a5a_5a5a_5a5a,
           1'b1, ERR_DECODE, '0);
   add_row("unmapped read", UMI_REQ_READ, unmapped, '0, 1'b1, ERR_DECODE, '0);
   add_row("atomic ctrl1", UMI_REQ_ATOMIC, ctrl_addr(1), 64'h1, 1'b1, ERR_DECODE, '0);
   add_row("ctrl1 after errors", UMI_REQ_READ, ctrl_addr(1), '0, 1'b1, ERR_OK, ctrl_val[1]);
   // Counter section, events go in before this row
   event_row = rows.size();
   for (int k = 0; k < N_CNT; k++)
      add_row($sformatf("cnt%0d events", k), UMI_REQ_READ, cnt_addr(k), '0,
              1'b1, ERR_OK, 64'(k + 3));
   add_row("cnt2 write", UMI_REQ_WRITE, cnt_addr(2), 64'h0123_4567_89ab_cdef,
           1'b1, ERR_OK, '0);
   add_row("cnt2 read", UMI_REQ_READ, cnt_addr(2), '0, 1'b1, ERR_OK, 64'h0123_4567_89ab_cdef);
endtask

// ==== verif/tb_umi_reg_top.sv ====
// UMI register target testbench
`timescale 1ns/100ps
module tb_umi_reg_top;

   import umi_reg_pkg::*;

   localparam int GRPOFFSET  = 24;
   localparam int GRPID      = 3;
   localparam int REQ_DEPTH  = 4;
   localparam int RESP_DEPTH = 4;
   localparam int N_CTRL     = 8;
   localparam int N_CNT      = 4;

   typedef struct packed {
      logic [4:0]  op;
      logic [63:0] addr;
      logic [63:0] data;
      logic        resp;    // Response expected
      logic [1:0]  err;
      logic [63:0] rdata;
   } row_t;

   typedef struct packed {
      logic [31:0] cmd;
      logic [63:0] dst;
      logic [63:0] data;
   } exp_t;

   logic             clk = 1'b0;
   logic             nreset;
   logic             req_valid;
   logic [31:0]      req_cmd;
   logic [63:0]      req_dstaddr;
   logic [63:0]      req_srcaddr;
   logic [63:0]      req_data;
   logic             req_credit;
   logic             resp_valid;
   logic [31:0]      resp_cmd;
   logic [63:0]      resp_dstaddr;
   logic [63:0]      resp_srcaddr;
   logic [63:0]      resp_data;
   logic             resp_credit = 1'b0;
   logic [N_CNT-1:0] event_in;

   row_t  rows [$];
   string row_name [$];
   exp_t  exp_q [$];           // Responses in request order
   string exp_name [$];
   int    event_row = -1;      // Counter events go in before this row
   int    sent = 0;            // Requests driven
   int    credit_returns = 0;  // req_credit pulses seen
   int    resp_seen = 0;
   int    resp_owed = 0;       // Responding requests queued so far
   int    grants = 0;
   int    gap = 0;             // Idle cycles before next grant
   logic  grant_en = 1'b0;
   int    watch_cycles = 0;

   // Default map, group 3 in dstaddr[27:24]
   umi_reg_top dut0 (.*);

   always #4 clk = ~clk;   // 8 ns period

   //##############################
   // Helpers
   //##############################
   task automatic stop_run();
      $display("Errors found");
      $fatal(1, "Run stopped on first failure");
   endtask

   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      if (expected !== actual)
      begin
         $display("ERROR %s expected %h actual %h", name, expected, actual);
         stop_run();
      end
   endtask

   // Word index inside this device's group
   function automatic logic [63:0] word_addr(input int w);
      return 64'(w << REG_IDX_LSB) | (64'(GRPID) << GRPOFFSET);
   endfunction

   function automatic logic [63:0] ctrl_addr(input int i);
      return word_addr(CTRL_BASE + i);
   endfunction

   function automatic logic [63:0] cnt_addr(input int k);
      return word_addr(CNT_BASE + k);
   endfunction

   task automatic add_row(input string name, input logic [4:0] op, input logic [63:0] addr,
                          input logic [63:0] data, input logic resp, input logic [1:0] err,
                          input logic [63:0] rdata);
      rows.push_back('{op, addr, data, resp, err, rdata});
      row_name.push_back(name);
   endtask

   `include "tb_vectors.svh"

   // One request per call, back to back while credits last
   task automatic send_req(input logic [31:0] cmd, input logic [63:0] addr,
                           input logic [63:0] data, input logic [63:0] src);
      @(posedge clk);
      req_valid <= 1'b0;
      while (sent - credit_returns >= REQ_DEPTH)   // Out of request credits
         @(posedge clk);
      req_valid   <= 1'b1;
      req_cmd     <= cmd;
      req_dstaddr <= addr;
      req_srcaddr <= src;
      req_data    <= data;
      sent = sent + 1;
   endtask

   task automatic apply_row(input int i);
      umi_cmd_t    c;
      umi_cmd_t    e;
      logic [63:0] src;
      c            = '0;
      c.req.opcode = rows[i].op;
      c.req.size   = 3'd3;
      c.req.len    = 8'(i);                        // Echo check per row
      src          = 64'h0000_00a0_0000_0000 | 64'(i);
      if (rows[i].resp)
      begin
         e             = '0;
         e.resp.opcode = (rows[i].op == UMI_REQ_WRITE) ? UMI_RESP_WRITE : UMI_RESP_READ;
         e.resp.size   = 3'd3;
         e.resp.len    = 8'(i);
         e.resp.err    = rows[i].err;
         exp_q.push_back('{e, src, rows[i].rdata});   // Reply goes back to src
         exp_name.push_back(row_name[i]);
         resp_owed <= resp_owed + 1;
      end
      send_req(c, rows[i].addr, rows[i].data, src);
   endtask

   // Wait until every request is issued and answered
   task automatic drain();
      @(posedge clk);
      req_valid <= 1'b0;
      while (resp_seen != resp_owed || sent != credit_returns)
         @(posedge clk);
   endtask

   // Bit k high for k+3 cycles
   task automatic pulse_events();
      logic [N_CNT-1:0] m;
      for (int c = 0; c < N_CNT + 2; c++)
      begin
         for (int k = 0; k < N_CNT; k++)
            m[k] = (c < k + 3);
         @(posedge clk);
         event_in <= m;
      end
      @(posedge clk);
      event_in <= '0;
   endtask

   //##############################
   // Host credit and response side
   //##############################
   always @(posedge clk)
   begin
      if (grant_en && grants < resp_owed && gap == 0)
      begin
         resp_credit <= 1'b1;
         grants      <= grants + 1;
         gap         <= int'($urandom_range(3, 0));   // Random spacing
      end
      else
      begin
         resp_credit <= 1'b0;
         if (gap != 0)
            gap <= gap - 1;
      end
   end

   always @(posedge clk)
   begin : resp_monitor
      exp_t  e;
      string nm;
      if (req_credit === 1'b1)
         credit_returns <= credit_returns + 1;
      if (resp_valid === 1'b1)
      begin
         if (exp_q.size() == 0)
         begin
            $display("A response arrived while none was expected");
            stop_run();
         end
         else
         begin
            e  = exp_q.pop_front();
            nm = exp_name.pop_front();
            check_value({nm, " cmd"}, 64'(e.cmd), 64'(resp_cmd));
            check_value({nm, " dstaddr"}, e.dst, resp_dstaddr);
            check_value({nm, " srcaddr"}, '0, resp_srcaddr);
            check_value({nm, " data"}, e.data, resp_data);
            resp_seen <= resp_seen + 1;
         end
      end
   end

   initial
   begin : watchdog
      wait (watch_cycles != 0);
      repeat (watch_cycles) @(posedge clk);
      $display("Timeout after %0d cycles, responses stopped arriving", watch_cycles);
      stop_run();
   end

   //##############################
   // Main sequence
   //##############################
   initial
   begin : main
      int          burst_first;
      int          burst_returns;
      int          burst_resp;
      logic [63:0] d;
      void'($urandom(32'h5619_7f4b));
      nreset      <= 1'b0;
      req_valid   <= 1'b0;
      req_cmd     <= '0;
      req_dstaddr <= '0;
      req_srcaddr <= '0;
      req_data    <= '0;
      event_in    <= '0;
      repeat (2) @(posedge clk);
      nreset <= 1'b1;
      @(posedge clk);
      check_value("reset resp_valid", 64'(0), 64'(resp_valid));
      check_value("reset req_credit", 64'(0), 64'(req_credit));

      load_vectors();
      watch_cycles = (rows.size() + 2 * RESP_DEPTH) * 50 + 100;   // Burst rows, counter phase
      grant_en <= 1'b1;
      for (int i = 0; i < rows.size(); i++)
      begin
         if (i == event_row)
         begin
            drain();          // Bus idle while counting
            pulse_events();
         end
         apply_row(i);
      end
      drain();

      // Burst with response credits withheld
      grant_en <= 1'b0;
      burst_first = rows.size();
      for (int j = 0; j < RESP_DEPTH; j++)
      begin
         d = {$urandom, $urandom};
         add_row($sformatf("burst ctrl%0d write", j), UMI_REQ_WRITE, ctrl_addr(j), d,
                 1'b1, ERR_OK, '0);
      end
      for (int j = 0; j < RESP_DEPTH; j++)
         add_row($sformatf("burst ctrl%0d read", j), UMI_REQ_READ, ctrl_addr(j), '0,
                 1'b1, ERR_OK, rows[burst_first + j].data);
      burst_returns = credit_returns;
      burst_resp    = resp_seen;
      for (int i = burst_first; i < rows.size(); i++)
         apply_row(i);
      @(posedge clk);
      req_valid <= 1'b0;
      repeat (12) @(posedge clk);   // Let the stall settle
      check_value("burst stalled issues", 64'(RESP_DEPTH), 64'(credit_returns - burst_returns));
      check_value("burst stalled responses", 64'(0), 64'(resp_seen - burst_resp));
      grant_en <= 1'b1;
      drain();
      check_value("burst credit total", 64'(2 * RESP_DEPTH), 64'(credit_returns - burst_returns));

      $display("No errors");
      $finish;
   end

endmodule

// ==== vlog.f ====
+incdir+verif
logic/umi_reg_pkg.sv
logic/reg_access_if.sv
logic/umi_regif.sv
logic/ctrl_regs.sv
logic/event_counters.sv
logic/resp_merge.sv
logic/umi_reg_top.sv
verif/tb_umi_reg_top.sv
